//--- source/robotron_consts.svh
////////////////////////////////////////
// Robotron glue constants
// Game codes, download indexes, stick
// thresholds, blanking and aspect sizes
////////////////////////////////////////
`ifndef ROBOTRON_CONSTS_SVH
`define ROBOTRON_CONSTS_SVH

// Game selection codes
`define GAME_ROBOTRON 0
`define GAME_JOUST    1
`define GAME_SPLAT    2
`define GAME_BUBBLES  3
`define GAME_STARGATE 4
`define GAME_ALIENAR  5
`define GAME_SINISTAR 6
`define GAME_PLAYBALL 7

// Download stream indexes
`define DL_INDEX_GAME 1
`define DL_INDEX_DIP  254

// Analog stick thresholds, signed magnitude
`define AXIS_T1 32
`define AXIS_T2 64
`define AXIS_T3 96

// Blanking edges, pixel pairs and lines
`define HBLANK_ON  336
`define HBLANK_OFF 40
`define VBLANK_ON  254
`define VBLANK_OFF 14

// Display aspect sizes
`define ASPECT_LONG  1184
`define ASPECT_SHORT 939

`endif

//--- source/robotron_pkg.sv
////////////////////////////////////////
// Robotron glue types
// Vector types shared by the glue blocks
////////////////////////////////////////
package robotron_pkg;

	// Selected game number
	typedef logic [7:0] game_code_t;

	// Board input port or DIP byte
	typedef logic [7:0] port_byte_t;

	// Download address
	typedef logic [24:0] dl_addr_t;

	// Joystick word: 3:0 right/left/down/up, 9:4 fire a-f,
	// 15:10 start1, start2, coin, advance, autoup, pause
	typedef logic [15:0] joy_word_t;

	// Analog stick, signed X in the low byte, signed Y in the high byte
	typedef logic [15:0] axis_pair_t;

	// Quantized stick position, 7 is centre
	typedef logic [3:0] stick_pos_t;

	// Pixel and line counters
	typedef logic [10:0] pix_cnt_t;

	typedef logic [12:0] aspect_t;
	typedef logic [15:0] sample_t;

endpackage

//--- source/config_loader.sv
////////////////////////////////////////
// Configuration loader
// Captures the game code and DIP byte 0
// from download port writes
////////////////////////////////////////
`timescale 1ns/1ns
`include "robotron_consts.svh"

module config_loader
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    dl_wr,
	input  robotron_pkg::port_byte_t dl_index,
	input  robotron_pkg::dl_addr_t   dl_addr,
	input  robotron_pkg::port_byte_t dl_data,
	output robotron_pkg::game_code_t game,
	output robotron_pkg::port_byte_t dip0
);
	import robotron_pkg::*;

	logic game_wr;
	logic dip0_wr;

	// Only DIP byte 0 is kept, other DIP addresses fall through
	assign game_wr = dl_wr && (dl_index == port_byte_t'(`DL_INDEX_GAME));
	assign dip0_wr = dl_wr && (dl_index == port_byte_t'(`DL_INDEX_DIP)) &&
		(dl_addr == '0);

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			game <= '0;
			dip0 <= '0;
		end
		else
		begin
			if (game_wr)
				game <= game_code_t'(dl_data);
			if (dip0_wr)
				dip0 <= dl_data;
		end
	end

endmodule

//--- source/analog_quantizer.sv
////////////////////////////////////////
// Analog stick quantizer
// Follows the last active player and turns
// its stick into 4-bit board positions
////////////////////////////////////////
`timescale 1ns/1ns
`include "robotron_consts.svh"

module analog_quantizer
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  robotron_pkg::joy_word_t  joy1,
	input  robotron_pkg::joy_word_t  joy2,
	input  robotron_pkg::axis_pair_t joy1_analog,
	input  robotron_pkg::axis_pair_t joy2_analog,
	output robotron_pkg::stick_pos_t stick_x,
	output robotron_pkg::stick_pos_t stick_y
);
	import robotron_pkg::*;

	logic       use_p2;
	joy_word_t  joy_any;
	axis_pair_t joy_a;
	stick_pos_t ana_x;
	stick_pos_t ana_y;
	stick_pos_t dig_x;
	stick_pos_t dig_y;

	// Threshold ladder, swap mirrors the codes for the Y axis
	function automatic stick_pos_t quant_axis(input logic signed [7:0] v, input logic swap);
		stick_pos_t pos;
		if (v < -`AXIS_T3)
			pos = swap ? 4'd8 : 4'd0;
		else if (v < -`AXIS_T2)
			pos = swap ? 4'd9 : 4'd4;
		else if (v < -`AXIS_T1)
			pos = swap ? 4'd11 : 4'd6;
		else if (v > `AXIS_T3)
			pos = swap ? 4'd0 : 4'd8;
		else if (v > `AXIS_T2)
			pos = swap ? 4'd4 : 4'd9;
		else if (v > `AXIS_T1)
			pos = swap ? 4'd6 : 4'd11;
		else
			pos = 4'd7;
		return pos;
	endfunction

	assign joy_any = joy1 | joy2;
	assign joy_a   = use_p2 ? joy2_analog : joy1_analog;
	assign ana_x   = quant_axis(joy_a[7:0], 1'b0);
	assign ana_y   = quant_axis(joy_a[15:8], 1'b1);

	// Digital directions from either stick
	assign dig_x = joy_any[1] ? 4'd0 : (joy_any[0] ? 4'd8 : 4'd7);
	assign dig_y = joy_any[2] ? 4'd0 : (joy_any[3] ? 4'd8 : 4'd7);

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			use_p2  <= 1'b0;
			stick_x <= 4'd7;
			stick_y <= 4'd7;
		end
		else
		begin
			// Player 1 has priority when both move
			if (joy1 != '0)
				use_p2 <= 1'b0;
			else if (joy2 != '0)
				use_p2 <= 1'b1;
			stick_x <= (ana_x == 4'd7) ? dig_x : ana_x;
			stick_y <= (ana_y == 4'd7) ? dig_y : ana_y;
		end
	end

endmodule

//--- source/control_mapper.sv
////////////////////////////////////////
// Control mapper
// Per-game mapping of sticks and buttons
// onto the board's active-low input ports
////////////////////////////////////////
`timescale 1ns/1ns
`include "robotron_consts.svh"

module control_mapper
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  robotron_pkg::game_code_t game,
	input  robotron_pkg::port_byte_t dip0,
	input  robotron_pkg::joy_word_t  joy1,
	input  robotron_pkg::joy_word_t  joy2,
	input  robotron_pkg::stick_pos_t stick_x,
	input  robotron_pkg::stick_pos_t stick_y,
	input  logic [1:0]              ctrl_mode,
	input  logic                    sg_state,
	output robotron_pkg::port_byte_t ja,
	output robotron_pkg::port_byte_t jb,
	output robotron_pkg::port_byte_t sw,
	output logic [2:0]              btn,
	output logic                    sin_fire,
	output logic                    sin_bomb,
	output logic                    blitter_sc2,
	output logic                    sinistar,
	output logic                    landscape
);
	import robotron_pkg::*;

	joy_word_t  both;
	port_byte_t ja_act;
	port_byte_t jb_act;
	logic [2:0] btn_nxt;
	logic       sc2_nxt;
	logic       sini_nxt;
	logic       land_nxt;
	logic       thrust;
	logic       reverse;

	// Right, left, down, up
	function automatic logic [3:0] dir_nib(input joy_word_t j);
		return {j[0], j[1], j[2], j[3]};
	endfunction

	// Fire a, d, b, c
	function automatic logic [3:0] fire_nib(input joy_word_t j);
		return {j[4], j[7], j[5], j[6]};
	endfunction

	assign both = joy1 | joy2;

	// Stargate thrust and reverse depend on the control mode
	assign thrust = (ctrl_mode == 2'b10) ? both[8] :
		(ctrl_mode[0] ? (sg_state ? both[0] : both[1]) : (both[1] | both[0]));
	assign reverse = ctrl_mode[0] ? (sg_state ? both[1] : both[0]) : both[5];

	////////////////////////////////////////
	// Active-high port values per game
	always_comb
	begin
		ja_act   = '0;
		jb_act   = '0;
		btn_nxt  = '0;
		sc2_nxt  = 1'b0;
		sini_nxt = 1'b0;
		land_nxt = 1'b1;
		case (game)
			`GAME_ROBOTRON:
			begin
				btn_nxt = {both[10], both[11], both[12]};
				ja_act  = {ctrl_mode[1] ? dir_nib(joy2) :
					(ctrl_mode[0] ? dir_nib(both) : fire_nib(both)),
					ctrl_mode[1] ? dir_nib(joy1) : dir_nib(both)};
				jb_act  = ja_act;
			end
			`GAME_JOUST:
			begin
				btn_nxt = {both[11], both[10], both[12]};
				ja_act  = {5'b00000, joy1[4], joy1[0], joy1[1]};
				jb_act  = {5'b00000, joy2[4], joy2[0], joy2[1]};
			end
			`GAME_SPLAT:
			begin
				sc2_nxt = 1'b1;
				btn_nxt = {both[10], both[11], both[12]};
				ja_act  = {ctrl_mode[0] ? dir_nib(joy1) : fire_nib(joy1), dir_nib(joy1)};
				jb_act  = {ctrl_mode[0] ? dir_nib(joy2) : fire_nib(joy2), dir_nib(joy2)};
			end
			`GAME_BUBBLES:
			begin
				btn_nxt = {both[11], both[10], both[12]};
				ja_act  = {4'b0000, dir_nib(both)};
				jb_act  = ja_act;
			end
			`GAME_STARGATE:
			begin
				btn_nxt = {both[11], both[10], both[12]};
				ja_act  = {both[9], both[3], both[2], thrust, both[7], both[6], reverse, both[4]};
				jb_act  = ja_act;
			end
			`GAME_ALIENAR:
			begin
				btn_nxt = {both[10], both[11], both[12]};
				ja_act  = {2'b00, joy1[5], joy1[4], dir_nib(joy1)};
				jb_act  = {2'b00, joy2[5], joy2[4], dir_nib(joy2)};
			end
			`GAME_SINISTAR:
			begin
				sini_nxt = 1'b1;
				land_nxt = 1'b0;
				btn_nxt  = {both[10], both[11], both[12]};
				ja_act   = {stick_x, stick_y};
				jb_act   = ja_act;
			end
			`GAME_PLAYBALL:
			begin
				land_nxt = 1'b0;
				btn_nxt  = {2'b00, both[12]};
				ja_act   = {4'b0000, both[11], both[0], both[1], both[10]};
				jb_act   = ja_act;
			end
			default:
			begin
				ja_act = '0;
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ja          <= '1;
			jb          <= '1;
			btn         <= '0;
			sw          <= '0;
			sin_fire    <= 1'b1;
			sin_bomb    <= 1'b1;
			blitter_sc2 <= 1'b0;
			sinistar    <= 1'b0;
			landscape   <= 1'b1;
		end
		else
		begin
			ja          <= ~ja_act;
			jb          <= ~jb_act;
			btn         <= btn_nxt;
			// Advance on bit 1, auto up on bit 0
			sw          <= dip0 | {6'b000000, both[13], both[14]};
			sin_fire    <= ~both[4];
			sin_bomb    <= ~both[5];
			blitter_sc2 <= sc2_nxt;
			sinistar    <= sini_nxt;
			landscape   <= land_nxt;
		end
	end

endmodule

//--- source/av_output.sv
////////////////////////////////////////
// Video timing and audio output
// Blanking from sync edges, pixel enable,
// sound mix and aspect ratio select
////////////////////////////////////////
`timescale 1ns/1ns
`include "robotron_consts.svh"

module av_output
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    hs,
	input  logic                    vs,
	input  logic                    landscape,
	input  logic                    orient_horz,
	input  logic [1:0]              aspect_sel,
	input  robotron_pkg::port_byte_t audio,
	input  robotron_pkg::sample_t    speech,
	output logic                    hblank,
	output logic                    vblank,
	output logic                    ce_pix,
	output robotron_pkg::aspect_t    video_arx,
	output robotron_pkg::aspect_t    video_ary,
	output robotron_pkg::sample_t    audio_l
);
	import robotron_pkg::*;

	pix_cnt_t    pcnt;
	pix_cnt_t    lcnt;
	logic        hs_d;
	logic        vs_d;
	logic        hs_rise;
	logic [16:0] audsum;

	assign hs_rise = hs & ~hs_d;
	assign ce_pix  = pcnt[0];
	// Sound board byte sits above the speech sample
	assign audsum  = {1'b0, audio, 8'd0} + {1'b0, speech};

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pcnt    <= '0;
			lcnt    <= '0;
			hs_d    <= 1'b0;
			vs_d    <= 1'b0;
			hblank  <= 1'b1;
			vblank  <= 1'b1;
			audio_l <= '0;
		end
		else
		begin
			hs_d <= hs;
			if (hs_rise)
			begin
				pcnt <= '0;
				// vs is only looked at on line starts
				vs_d <= vs;
				if (vs & ~vs_d)
					lcnt <= '0;
				else if (~&lcnt)
					lcnt <= lcnt + 1'b1;
			end
			else if (~&pcnt)
				pcnt <= pcnt + 1'b1;

			if (pcnt[10:1] == 10'(`HBLANK_ON))
				hblank <= 1'b1;
			else if (pcnt[10:1] == 10'(`HBLANK_OFF))
				hblank <= 1'b0;
			if (lcnt == pix_cnt_t'(`VBLANK_ON))
				vblank <= 1'b1;
			else if (lcnt == pix_cnt_t'(`VBLANK_OFF))
				vblank <= 1'b0;

			audio_l <= sample_t'(audsum >> 3);
		end
	end

	////////////////////////////////////////
	// Aspect ratio, original or custom slot
	always_ff @(posedge clk_sys)
	begin
		if (aspect_sel == 2'd0)
		begin
			video_arx <= (landscape | orient_horz) ? aspect_t'(`ASPECT_LONG) : aspect_t'(`ASPECT_SHORT);
			video_ary <= (landscape | orient_horz) ? aspect_t'(`ASPECT_SHORT) : aspect_t'(`ASPECT_LONG);
		end
		else
		begin
			video_arx <= aspect_t'(aspect_sel) - aspect_t'(1);
			video_ary <= '0;
		end
	end

endmodule

//--- source/robotron_glue_top.sv
////////////////////////////////////////
// Robotron glue top level
// Config, controls, analog, video timing
// and audio around the board core
////////////////////////////////////////
`timescale 1ns/1ns

module robotron_glue_top
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	// Download port
	input  logic                    dl_wr,
	input  robotron_pkg::port_byte_t dl_index,
	input  robotron_pkg::dl_addr_t   dl_addr,
	input  robotron_pkg::port_byte_t dl_data,
	// Player controls
	input  robotron_pkg::joy_word_t  joy1,
	input  robotron_pkg::joy_word_t  joy2,
	input  robotron_pkg::axis_pair_t joy1_analog,
	input  robotron_pkg::axis_pair_t joy2_analog,
	input  logic [1:0]              ctrl_mode,
	input  logic                    sg_state,
	// Board video and sound
	input  logic                    hs,
	input  logic                    vs,
	input  logic                    orient_horz,
	input  logic [1:0]              aspect_sel,
	input  robotron_pkg::port_byte_t audio,
	input  robotron_pkg::sample_t    speech,
	// Board input ports and mode flags
	output robotron_pkg::port_byte_t ja,
	output robotron_pkg::port_byte_t jb,
	output robotron_pkg::port_byte_t sw,
	output logic [2:0]              btn,
	output logic                    sin_fire,
	output logic                    sin_bomb,
	output logic                    blitter_sc2,
	output logic                    sinistar,
	output logic                    landscape,
	// Video and audio out
	output logic                    hblank,
	output logic                    vblank,
	output logic                    ce_pix,
	output robotron_pkg::aspect_t    video_arx,
	output robotron_pkg::aspect_t    video_ary,
	output robotron_pkg::sample_t    audio_l
);
	import robotron_pkg::*;

	game_code_t game;
	port_byte_t dip0;
	stick_pos_t stick_x;
	stick_pos_t stick_y;

	config_loader u_config
	(
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dip0     (dip0)
	);

	analog_quantizer u_analog
	(
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.joy1        (joy1),
		.joy2        (joy2),
		.joy1_analog (joy1_analog),
		.joy2_analog (joy2_analog),
		.stick_x     (stick_x),
		.stick_y     (stick_y)
	);

	control_mapper u_controls
	(
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.game        (game),
		.dip0        (dip0),
		.joy1        (joy1),
		.joy2        (joy2),
		.stick_x     (stick_x),
		.stick_y     (stick_y),
		.ctrl_mode   (ctrl_mode),
		.sg_state    (sg_state),
		.ja          (ja),
		.jb          (jb),
		.sw          (sw),
		.btn         (btn),
		.sin_fire    (sin_fire),
		.sin_bomb    (sin_bomb),
		.blitter_sc2 (blitter_sc2),
		.sinistar    (sinistar),
		.landscape   (landscape)
	);

	// Landscape from the mapper also picks the aspect ratio
	av_output u_av
	(
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.hs          (hs),
		.vs          (vs),
		.landscape   (landscape),
		.orient_horz (orient_horz),
		.aspect_sel  (aspect_sel),
		.audio       (audio),
		.speech      (speech),
		.hblank      (hblank),
		.vblank      (vblank),
		.ce_pix      (ce_pix),
		.video_arx   (video_arx),
		.video_ary   (video_ary),
		.audio_l     (audio_l)
	);

endmodule

//--- verification/tb_robotron_glue.sv
////////////////////////////////////////
// Robotron glue testbench
// Self-checking run over config, control
// mapping, analog stick, blanking and audio
////////////////////////////////////////
`timescale 1ns/1ns
`include "robotron_consts.svh"

module tb_robotron_glue;

	localparam int CLK_PERIOD = 20;
	localparam int GAME_STEPS = 200;
	localparam int HS_PERIOD  = 720;
	localparam int HS_HIGH    = 32;
	localparam int LINES      = 262;
	localparam int VS_LINES   = 3;
	localparam int FRAMES     = 2;
	localparam int BLANK_CYCLES    = FRAMES * LINES * HS_PERIOD;
	localparam int WATCHDOG_CYCLES = BLANK_CYCLES + 9 * GAME_STEPS * 4 + 10000;

	logic        clk_sys;
	logic        rst_n;
	logic        dl_wr;
	logic [7:0]  dl_index;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic [15:0] joy1;
	logic [15:0] joy2;
	logic [15:0] joy1_analog;
	logic [15:0] joy2_analog;
	logic [1:0]  ctrl_mode;
	logic        sg_state;
	logic        hs;
	logic        vs;
	logic        orient_horz;
	logic [1:0]  aspect_sel;
	logic [7:0]  audio;
	logic [15:0] speech;
	logic [7:0]  ja;
	logic [7:0]  jb;
	logic [7:0]  sw;
	logic [2:0]  btn;
	logic        sin_fire;
	logic        sin_bomb;
	logic        blitter_sc2;
	logic        sinistar;
	logic        landscape;
	logic        hblank;
	logic        vblank;
	logic        ce_pix;
	logic [12:0] video_arx;
	logic [12:0] video_ary;
	logic [15:0] audio_l;

	// Expected values and the state of the compare process
	logic [7:0]  exp_ja;
	logic [7:0]  exp_jb;
	logic [7:0]  exp_sw;
	logic [2:0]  exp_btn;
	logic        exp_sfire;
	logic        exp_sbomb;
	logic [2:0]  exp_flags;
	logic [15:0] exp_audio;
	logic [12:0] exp_arx;
	logic [12:0] exp_ary;
	logic        exp_hblank;
	logic        exp_vblank;
	logic        exp_ce;
	logic        blank_on;
	int          chk_group;
	int          wait_cnt;
	int          checks;
	int          errors;

	// Model of the stored configuration and the active player
	logic [7:0]  ref_game;
	logic [7:0]  ref_dip;
	logic        ref_p2;
	logic [31:0] rng;

	// Sweep points on and around every stick threshold
	logic [7:0] axis_vals [0:15] = '{8'h80, 8'h9F, 8'hA0, 8'hA1, 8'hBF, 8'hC0, 8'hDF, 8'hE0,
		8'h00, 8'h20, 8'h21, 8'h40, 8'h41, 8'h60, 8'h61, 8'h7F};
	logic [7:0] aspect_games [0:2] = '{`GAME_ROBOTRON, `GAME_SINISTAR, `GAME_PLAYBALL};

	robotron_glue_top UUT
	(
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl_wr       (dl_wr),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.joy1        (joy1),
		.joy2        (joy2),
		.joy1_analog (joy1_analog),
		.joy2_analog (joy2_analog),
		.ctrl_mode   (ctrl_mode),
		.sg_state    (sg_state),
		.hs          (hs),
		.vs          (vs),
		.orient_horz (orient_horz),
		.aspect_sel  (aspect_sel),
		.audio       (audio),
		.speech      (speech),
		.ja          (ja),
		.jb          (jb),
		.sw          (sw),
		.btn         (btn),
		.sin_fire    (sin_fire),
		.sin_bomb    (sin_bomb),
		.blitter_sc2 (blitter_sc2),
		.sinistar    (sinistar),
		.landscape   (landscape),
		.hblank      (hblank),
		.vblank      (vblank),
		.ce_pix      (ce_pix),
		.video_arx   (video_arx),
		.video_ary   (video_ary),
		.audio_l     (audio_l)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Right, left, down, up from bit 3 down
	function automatic logic [3:0] dir_bits(input logic [15:0] j);
		return {j[0], j[1], j[2], j[3]};
	endfunction

	// Fire a, d, b, c from bit 3 down
	function automatic logic [3:0] fire_bits(input logic [15:0] j);
		return {j[4], j[7], j[5], j[6]};
	endfunction

	// Signed threshold band, -3 to 3
	function automatic int axis_region(input logic signed [7:0] v);
		int r;
		r = 0;
		if (v > `AXIS_T1)
			r = 1;
		if (v > `AXIS_T2)
			r = 2;
		if (v > `AXIS_T3)
			r = 3;
		if (v < -`AXIS_T1)
			r = -1;
		if (v < -`AXIS_T2)
			r = -2;
		if (v < -`AXIS_T3)
			r = -3;
		return r;
	endfunction

	function automatic logic [3:0] x_code(input int r);
		case (r)
			-3: return 4'd0;
			-2: return 4'd4;
			-1: return 4'd6;
			1: return 4'd11;
			2: return 4'd9;
			3: return 4'd8;
			default: return 4'd7;
		endcase
	endfunction

	// Quantized {x, y}, Y codes are the X codes of the mirrored band
	function automatic logic [7:0] ref_stick(input logic [15:0] a, input logic [15:0] b);
		logic [3:0] sx;
		logic [3:0] sy;
		sx = x_code(axis_region(a[7:0]));
		sy = x_code(-axis_region(a[15:8]));
		if (sx == 4'd7)
			sx = b[1] ? 4'd0 : (b[0] ? 4'd8 : 4'd7);
		if (sy == 4'd7)
			sy = b[2] ? 4'd0 : (b[3] ? 4'd8 : 4'd7);
		return {sx, sy};
	endfunction

	// Returns {ja, jb} as driven on the active-low ports
	function automatic logic [15:0] ref_ports(input logic [7:0] g, input logic [15:0] j1,
		input logic [15:0] j2, input logic [1:0] cm, input logic sg, input logic [7:0] st);
		logic [15:0] b;
		logic [7:0]  pa;
		logic [7:0]  pb;
		logic        th;
		logic        rv;
		b  = j1 | j2;
		pa = 8'h00;
		pb = 8'h00;
		case (g)
			`GAME_ROBOTRON:
			begin
				pa[3:0] = cm[1] ? dir_bits(j1) : dir_bits(b);
				if (cm[1])
					pa[7:4] = dir_bits(j2);
				else if (cm[0])
					pa[7:4] = dir_bits(b);
				else
					pa[7:4] = fire_bits(b);
				pb = pa;
			end
			`GAME_JOUST:
			begin
				pa = {5'd0, j1[4], j1[0], j1[1]};
				pb = {5'd0, j2[4], j2[0], j2[1]};
			end
			`GAME_SPLAT:
			begin
				pa = {cm[0] ? dir_bits(j1) : fire_bits(j1), dir_bits(j1)};
				pb = {cm[0] ? dir_bits(j2) : fire_bits(j2), dir_bits(j2)};
			end
			`GAME_BUBBLES:
			begin
				pa = {4'd0, dir_bits(b)};
				pb = pa;
			end
			`GAME_STARGATE:
			begin
				if (cm == 2'd2)
					th = b[8];
				else if (cm[0])
					th = sg ? b[0] : b[1];
				else
					th = b[0] | b[1];
				if (cm[0])
					rv = sg ? b[1] : b[0];
				else
					rv = b[5];
				pa = {b[9], b[3], b[2], th, b[7], b[6], rv, b[4]};
				pb = pa;
			end
			`GAME_ALIENAR:
			begin
				pa = {2'd0, j1[5], j1[4], dir_bits(j1)};
				pb = {2'd0, j2[5], j2[4], dir_bits(j2)};
			end
			`GAME_SINISTAR:
			begin
				pa = st;
				pb = pa;
			end
			`GAME_PLAYBALL:
			begin
				pa = {4'd0, b[11], b[0], b[1], b[10]};
				pb = pa;
			end
			default:
			begin
				pa = 8'h00;
				pb = 8'h00;
			end
		endcase
		return ~{pa, pb};
	endfunction

	function automatic logic [2:0] ref_btn(input logic [7:0] g, input logic [15:0] b);
		case (g)
			`GAME_ROBOTRON, `GAME_SPLAT, `GAME_ALIENAR, `GAME_SINISTAR:
				return {b[10], b[11], b[12]};
			`GAME_JOUST, `GAME_BUBBLES, `GAME_STARGATE:
				return {b[11], b[10], b[12]};
			`GAME_PLAYBALL:
				return {2'b00, b[12]};
			default:
				return 3'b000;
		endcase
	endfunction

	// blitter_sc2, sinistar, landscape
	function automatic logic [2:0] ref_flags(input logic [7:0] g);
		case (g)
			`GAME_SPLAT: return 3'b101;
			`GAME_SINISTAR: return 3'b010;
			`GAME_PLAYBALL: return 3'b000;
			default: return 3'b001;
		endcase
	endfunction

	function automatic logic [15:0] ref_audio(input logic [7:0] a, input logic [15:0] s);
		logic [16:0] sum;
		sum = {1'b0, a, 8'h00} + {1'b0, s};
		return {2'b00, sum[16:3]};
	endfunction

	// Returns {arx, ary}
	function automatic logic [25:0] ref_aspect(input logic [1:0] sel, input logic land,
		input logic horz);
		if (sel != 2'd0)
			return {11'd0, sel - 2'd1, 13'd0};
		else if (land | horz)
			return {13'(`ASPECT_LONG), 13'(`ASPECT_SHORT)};
		else
			return {13'(`ASPECT_SHORT), 13'(`ASPECT_LONG)};
	endfunction

	// k is the pixel counter value, blanking follows one edge later
	function automatic logic ref_hblank(input int k);
		return (k <= 2 * `HBLANK_OFF) || (k > 2 * `HBLANK_ON);
	endfunction

	function automatic logic ref_vblank(input int n, input int k);
		int m;
		// Line count seen on the previous edge
		m = (k == 0) ? n - 1 : n;
		return (m >= `VBLANK_ON) || (m < `VBLANK_OFF);
	endfunction

	////////////////////////////////////////
	// Compare process

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks = checks + 1;
		if (got !== expected)
		begin
			errors = errors + 1;
			$display("FAILED %s got %h expected %h at %0t", name, got, expected, $time);
		end
	endtask

	always @(negedge clk_sys)
	begin
		if (blank_on)
		begin
			check_value("hblank", hblank, exp_hblank);
			check_value("vblank", vblank, exp_vblank);
			check_value("ce_pix", ce_pix, exp_ce);
		end
		if (wait_cnt != 0)
		begin
			wait_cnt = wait_cnt - 1;
			if (wait_cnt == 0)
			begin
				case (chk_group)
					0:
					begin
						check_value("ja", ja, exp_ja);
						check_value("jb", jb, exp_jb);
						check_value("btn", btn, exp_btn);
						check_value("sw", sw, exp_sw);
						check_value("sin_fire", sin_fire, exp_sfire);
						check_value("sin_bomb", sin_bomb, exp_sbomb);
						check_value("blitter_sc2", blitter_sc2, exp_flags[2]);
						check_value("sinistar", sinistar, exp_flags[1]);
						check_value("landscape", landscape, exp_flags[0]);
					end
					1: check_value("audio_l", audio_l, exp_audio);
					2:
					begin
						check_value("video_arx", video_arx, exp_arx);
						check_value("video_ary", video_ary, exp_ary);
					end
					default:
					begin
						check_value("ja", ja, 8'hFF);
						check_value("jb", jb, 8'hFF);
						check_value("sw", sw, 8'h00);
						check_value("hblank", hblank, 1'b1);
					end
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Stimulus tasks

	task automatic load_byte(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		#2;
		dl_wr    = 1'b1;
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		@(posedge clk_sys);
		#2;
		dl_wr = 1'b0;
		if (index == `DL_INDEX_GAME)
			ref_game = data;
		if (index == `DL_INDEX_DIP && addr == 25'd0)
			ref_dip = data;
	endtask

	// lat is the number of edges from the inputs to the checked outputs
	task automatic apply_ctrl(input logic [15:0] j1, input logic [15:0] j2,
		input logic [15:0] a1, input logic [15:0] a2, input logic [1:0] cm,
		input logic sg, input int lat);
		logic [15:0] b;
		logic [7:0]  st;
		logic [15:0] ports;
		@(posedge clk_sys);
		#2;
		joy1        = j1;
		joy2        = j2;
		joy1_analog = a1;
		joy2_analog = a2;
		ctrl_mode   = cm;
		sg_state    = sg;
		if (j1 != 16'd0)
			ref_p2 = 1'b0;
		else if (j2 != 16'd0)
			ref_p2 = 1'b1;
		b         = j1 | j2;
		st        = ref_stick(ref_p2 ? a2 : a1, b);
		ports     = ref_ports(ref_game, j1, j2, cm, sg, st);
		exp_ja    = ports[15:8];
		exp_jb    = ports[7:0];
		exp_btn   = ref_btn(ref_game, b);
		exp_sw    = ref_dip | {6'd0, b[13], b[14]};
		exp_sfire = ~b[4];
		exp_sbomb = ~b[5];
		exp_flags = ref_flags(ref_game);
		chk_group = 0;
		wait_cnt  = lat + 1;
		wait (wait_cnt == 0);
	endtask

	task automatic apply_audio(input logic [7:0] a, input logic [15:0] s);
		@(posedge clk_sys);
		#2;
		audio     = a;
		speech    = s;
		exp_audio = ref_audio(a, s);
		chk_group = 1;
		wait_cnt  = 2;
		wait (wait_cnt == 0);
	endtask

	task automatic apply_aspect(input logic [1:0] sel, input logic horz);
		logic [2:0]  fl;
		logic [25:0] ar;
		@(posedge clk_sys);
		#2;
		aspect_sel  = sel;
		orient_horz = horz;
		fl          = ref_flags(ref_game);
		ar          = ref_aspect(sel, fl[0], horz);
		exp_arx     = ar[25:13];
		exp_ary     = ar[12:0];
		chk_group   = 2;
		wait_cnt    = 2;
		wait (wait_cnt == 0);
	endtask

	// Sync frames, each step sets what the DUT shows from the previous step
	task automatic run_blanking();
		int vn;
		int vk;
		for (int f = 0; f < FRAMES; f++)
			for (int n = 0; n < LINES; n++)
				for (int i = 0; i < HS_PERIOD; i++)
				begin
					@(posedge clk_sys);
					#2;
					vn = (i == 0) ? n - 1 : n;
					vk = (i == 0) ? HS_PERIOD - 1 : i - 1;
					if (!(f == 0 && n == 0 && i == 0))
					begin
						exp_hblank = ref_hblank(vk);
						exp_vblank = ref_vblank(vn, vk);
						exp_ce     = vk[0];
						blank_on   = 1'b1;
					end
					hs = (i < HS_HIGH);
					vs = (n < VS_LINES);
				end
		@(posedge clk_sys);
		#2;
		blank_on = 1'b0;
	endtask

	////////////////////////////////////////
	// Test sequence

	initial
	begin
		logic [31:0] r;
		logic [31:0] m;
		logic [15:0] ax;
		clk_sys     = 1'b0;
		rst_n       = 1'b0;
		dl_wr       = 1'b0;
		dl_index    = 8'd0;
		dl_addr     = 25'd0;
		dl_data     = 8'd0;
		joy1        = 16'd0;
		joy2        = 16'd0;
		joy1_analog = 16'd0;
		joy2_analog = 16'd0;
		ctrl_mode   = 2'd0;
		sg_state    = 1'b0;
		hs          = 1'b0;
		vs          = 1'b0;
		orient_horz = 1'b0;
		aspect_sel  = 2'd0;
		audio       = 8'd0;
		speech      = 16'd0;
		blank_on    = 1'b0;
		chk_group   = 0;
		wait_cnt    = 0;
		checks      = 0;
		errors      = 0;
		ref_game    = 8'd0;
		ref_dip     = 8'd0;
		ref_p2      = 1'b0;
		rng         = 32'd13245;

		repeat (2) @(posedge clk_sys);
		#2;
		rst_n     = 1'b1;
		chk_group = 3;
		wait_cnt  = 1;
		wait (wait_cnt == 0);

		// DIP byte 0 only, other addresses and indexes are dropped
		load_byte(`DL_INDEX_DIP, 25'd0, 8'hA4);
		apply_ctrl(16'd0, 16'd0, 16'd0, 16'd0, 2'd0, 1'b0, 1);
		load_byte(`DL_INDEX_DIP, 25'd3, 8'h5A);
		apply_ctrl(16'd0, 16'd0, 16'd0, 16'd0, 2'd0, 1'b0, 1);
		load_byte(8'd7, 25'd0, 8'h3C);
		apply_ctrl(16'd0, 16'd0, 16'd0, 16'd0, 2'd0, 1'b0, 1);

		// Code 8 is outside the game list
		for (int g = 0; g <= 8; g++)
		begin
			load_byte(`DL_INDEX_GAME, 25'd0, 8'(g));
			for (int i = 0; i < GAME_STEPS; i++)
			begin
				r = next_random();
				m = next_random();
				apply_ctrl(r[15:0], r[31:16], 16'd0, 16'd0, m[1:0], m[2],
					(g == `GAME_SINISTAR) ? 2 : 1);
			end
		end

		load_byte(`DL_INDEX_GAME, 25'd0, `GAME_SINISTAR);
		for (int p = 0; p < 2; p++)
		begin
			// Fire a makes player p the last one to move
			apply_ctrl(p == 0 ? 16'h0010 : 16'd0, p == 1 ? 16'h0010 : 16'd0,
				16'd0, 16'd0, 2'd0, 1'b0, 3);
			for (int i = 0; i < 16; i++)
			begin
				r  = next_random();
				ax = {axis_vals[15 - i], axis_vals[i]};
				apply_ctrl(16'd0, 16'd0, p == 0 ? ax : r[15:0], p == 1 ? ax : r[15:0],
					2'd0, 1'b0, 2);
			end
			// Centred sticks, just inside the first threshold
			for (int d = 0; d < 16; d++)
				apply_ctrl(p == 0 ? 16'(d) : 16'd0, p == 1 ? 16'(d) : 16'd0,
					16'h1FE1, 16'hE11F, 2'd0, 1'b0, 2);
		end

		for (int i = 0; i < GAME_STEPS; i++)
		begin
			r = next_random();
			apply_audio(r[7:0], r[31:16]);
		end

		for (int g = 0; g < 3; g++)
		begin
			load_byte(`DL_INDEX_GAME, 25'd0, aspect_games[g]);
			for (int o = 0; o < 2; o++)
				for (int s = 0; s < 4; s++)
					apply_aspect(2'(s), o[0]);
		end

		run_blanking();

		$display("Run complete: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the test sequence did not finish in time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- robotron_glue.f
+incdir+source
source/robotron_pkg.sv
source/config_loader.sv
source/analog_quantizer.sv
source/control_mapper.sv
source/av_output.sv
source/robotron_glue_top.sv
verification/tb_robotron_glue.sv
